/* verilog/bp_pkg.sv */
package bp_pkg;

    localparam int ADDR_W = 32;
    localparam int WORD_W = ADDR_W - 2;

    localparam int BP_INDEX_W = 4;
    localparam int BP_ENTRIES = 1 << BP_INDEX_W;

    // Queue slots double as the initial credit count
    localparam int QUEUE_DEPTH = 4;
    localparam int QPTR_W = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W = $clog2(QUEUE_DEPTH + 1);

    localparam logic [ADDR_W-1:0] RESET_PC = '0;

    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } ctr_state_e;

    typedef struct packed {
        logic [ADDR_W-1:0] pc;
        logic [ADDR_W-1:0] pred_next;
        logic              hit;
    } fetch_rec_t;

    typedef struct packed {
        logic              is_branch;
        logic              taken;
        logic [ADDR_W-1:0] target;
    } exec_resp_t;

    typedef struct packed {
        logic [ADDR_W-1:0] pc;
        logic              taken;
        logic [ADDR_W-1:0] target;
    } bp_update_t;

endpackage

/* verilog/branch_predictor.sv */
module branch_predictor (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [bp_pkg::ADDR_W-1:0] lookup_pc,
    input  logic                      update_valid,
    input  bp_pkg::bp_update_t        update,
    output logic                      pred_taken,
    output logic [bp_pkg::ADDR_W-1:0] pred_target,
    output logic                      hit
);
    import bp_pkg::*;

    logic [WORD_W-1:0] tag_mem    [BP_ENTRIES];
    logic [WORD_W-1:0] target_mem [BP_ENTRIES];
    logic              valid_q    [BP_ENTRIES];
    ctr_state_e        ctr_q      [BP_ENTRIES];

    logic [BP_INDEX_W-1:0] lookup_idx;
    logic [BP_INDEX_W-1:0] upd_idx;
    logic                  upd_hit;
    ctr_state_e            upd_ctr;

    // Lookup, same cycle
    assign lookup_idx  = lookup_pc[BP_INDEX_W+1:2];
    assign hit         = valid_q[lookup_idx] && (tag_mem[lookup_idx] == lookup_pc[ADDR_W-1:2]);
    assign pred_taken  = (ctr_q[lookup_idx] == WEAK_T) || (ctr_q[lookup_idx] == STRONG_T);
    assign pred_target = {target_mem[lookup_idx], 2'b00};

    assign upd_idx = update.pc[BP_INDEX_W+1:2];
    assign upd_hit = valid_q[upd_idx] && (tag_mem[upd_idx] == update.pc[ADDR_W-1:2]);

    // Saturating step of the trained entry
    always_comb begin
        case (ctr_q[upd_idx])
            STRONG_NT: upd_ctr = update.taken ? WEAK_NT  : STRONG_NT;
            WEAK_NT:   upd_ctr = update.taken ? WEAK_T   : STRONG_NT;
            WEAK_T:    upd_ctr = update.taken ? STRONG_T : WEAK_NT;
            default:   upd_ctr = update.taken ? STRONG_T : WEAK_T;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < BP_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
                ctr_q[i]   <= WEAK_NT;
            end
        end else if (update_valid) begin
            valid_q[upd_idx] <= 1'b1;
            // New branches start weakly taken
            ctr_q[upd_idx] <= upd_hit ? upd_ctr : WEAK_T;
        end
    end

    always_ff @(posedge clk) begin
        if (update_valid && !upd_hit) begin
            tag_mem[upd_idx]    <= update.pc[ADDR_W-1:2];
            target_mem[upd_idx] <= update.target[ADDR_W-1:2];
        end
    end

    // Resolve stage must come out of reset idle
    update_idle_after_reset: assert property (
        @(posedge clk) reset |=> !update_valid
    );

endmodule

/* verilog/fetch_pc_gen.sv */
module fetch_pc_gen (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      pred_taken,
    input  logic [bp_pkg::ADDR_W-1:0] pred_target,
    input  logic                      hit,
    input  logic                      credit_return,
    input  logic                      redirect,
    input  logic [bp_pkg::ADDR_W-1:0] redirect_pc,
    output logic [bp_pkg::ADDR_W-1:0] lookup_pc,
    output logic                      push,
    output bp_pkg::fetch_rec_t        rec
);
    import bp_pkg::*;

    logic [ADDR_W-1:0] pc_q;
    logic [ADDR_W-1:0] pred_next;
    logic [QCNT_W-1:0] credits_q;

    assign lookup_pc = pc_q;
    assign pred_next = (hit && pred_taken) ? pred_target : pc_q + ADDR_W'(4);

    // A redirect cycle never pushes, the record would be wrong path
    assign push = (credits_q != '0) && !redirect;

    assign rec.pc        = pc_q;
    assign rec.pred_next = pred_next;
    assign rec.hit       = hit;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= RESET_PC;
        end else if (redirect) begin
            pc_q <= redirect_pc;
        end else if (push) begin
            pc_q <= pred_next;
        end
    end

    // Flush empties the queue, so all credits come home at once
    always_ff @(posedge clk) begin
        if (reset) begin
            credits_q <= QCNT_W'(QUEUE_DEPTH);
        end else if (redirect) begin
            credits_q <= QCNT_W'(QUEUE_DEPTH);
        end else begin
            credits_q <= credits_q + QCNT_W'(credit_return) - QCNT_W'(push);
        end
    end

    credits_bounded: assert property (
        @(posedge clk) disable iff (reset) credits_q <= QCNT_W'(QUEUE_DEPTH)
    );

endmodule

/* verilog/fetch_queue.sv */
module fetch_queue (
    input  logic               clk,
    input  logic               reset,
    input  logic               push,
    input  bp_pkg::fetch_rec_t rec,
    input  logic               pop,
    input  logic               flush,
    output bp_pkg::fetch_rec_t head,
    output logic               head_valid,
    output logic               credit_return
);
    import bp_pkg::*;

    fetch_rec_t        mem [QUEUE_DEPTH];
    logic [QPTR_W-1:0] rd_ptr;
    logic [QPTR_W-1:0] wr_ptr;
    logic [QCNT_W-1:0] count;
    logic              do_pop;

    function automatic logic [QPTR_W-1:0] next_ptr(input logic [QPTR_W-1:0] ptr);
        logic [QPTR_W-1:0] nxt;
        if (ptr == QPTR_W'(QUEUE_DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign head       = mem[rd_ptr];
    assign head_valid = (count != '0);
    assign do_pop     = pop && head_valid;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            rd_ptr        <= '0;
            wr_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count         <= count + QCNT_W'(push) - QCNT_W'(do_pop);
            // One credit back per record taken
            credit_return <= do_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= rec;
        end
    end

    // Credits in the generator should keep this from ever firing
    no_push_when_full: assert property (
        @(posedge clk) disable iff (reset) push |-> (count != QCNT_W'(QUEUE_DEPTH))
    );

endmodule

/* verilog/branch_resolve.sv */
module branch_resolve (
    input  logic                      clk,
    input  logic                      reset,
    input  bp_pkg::fetch_rec_t        head,
    input  logic                      head_valid,
    input  logic                      exec_resp_valid,
    input  bp_pkg::exec_resp_t        exec_resp,
    output logic                      pop,
    output logic                      exec_req_valid,
    output bp_pkg::fetch_rec_t        exec_req,
    output logic                      update_valid,
    output bp_pkg::bp_update_t        update,
    output logic                      redirect,
    output logic [bp_pkg::ADDR_W-1:0] redirect_pc,
    output logic                      mispredict,
    output logic                      retire_valid
);
    import bp_pkg::*;

    logic [ADDR_W-1:0] actual_next;
    logic              wrong_path;
    logic              accept;

    // Head is wrong path while the redirect is still in flight
    assign exec_req_valid = head_valid && !redirect;
    assign exec_req       = head;

    assign accept = exec_req_valid && exec_resp_valid;
    assign pop    = accept;

    assign actual_next = (exec_resp.is_branch && exec_resp.taken) ? exec_resp.target
                                                                  : head.pc + ADDR_W'(4);
    assign wrong_path  = (actual_next != head.pred_next);

    always_ff @(posedge clk) begin
        if (reset) begin
            update_valid <= 1'b0;
            redirect     <= 1'b0;
            retire_valid <= 1'b0;
        end else begin
            update_valid <= accept && exec_resp.is_branch;
            redirect     <= accept && wrong_path;
            retire_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            update.pc     <= head.pc;
            update.taken  <= exec_resp.taken;
            update.target <= exec_resp.target;
            redirect_pc   <= actual_next;
        end
    end

    // Every mispredict is exactly one redirect
    assign mispredict = redirect;

endmodule

/* verilog/branch_frontend.sv */
module branch_frontend (
    input  logic               clk,
    input  logic               reset,
    input  logic               exec_resp_valid,
    input  bp_pkg::exec_resp_t exec_resp,
    output logic               exec_req_valid,
    output bp_pkg::fetch_rec_t exec_req,
    output logic               mispredict,
    output logic               retire_valid
);
    import bp_pkg::*;

    logic [ADDR_W-1:0] lookup_pc;
    logic              pred_taken;
    logic [ADDR_W-1:0] pred_target;
    logic              hit;
    logic              push;
    fetch_rec_t        rec;
    fetch_rec_t        head;
    logic              head_valid;
    logic              credit_return;
    logic              pop;
    logic              update_valid;
    bp_update_t        update;
    logic              redirect;
    logic [ADDR_W-1:0] redirect_pc;

    branch_predictor branch_predictor_inst (
        .clk          (clk),
        .reset        (reset),
        .lookup_pc    (lookup_pc),
        .update_valid (update_valid),
        .update       (update),
        .pred_taken   (pred_taken),
        .pred_target  (pred_target),
        .hit          (hit)
    );

    fetch_pc_gen fetch_pc_gen_inst (
        .clk           (clk),
        .reset         (reset),
        .pred_taken    (pred_taken),
        .pred_target   (pred_target),
        .hit           (hit),
        .credit_return (credit_return),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .lookup_pc     (lookup_pc),
        .push          (push),
        .rec           (rec)
    );

    // Redirect also flushes the queue
    fetch_queue fetch_queue_inst (
        .clk           (clk),
        .reset         (reset),
        .push          (push),
        .rec           (rec),
        .pop           (pop),
        .flush         (redirect),
        .head          (head),
        .head_valid    (head_valid),
        .credit_return (credit_return)
    );

    branch_resolve branch_resolve_inst (
        .clk             (clk),
        .reset           (reset),
        .head            (head),
        .head_valid      (head_valid),
        .exec_resp_valid (exec_resp_valid),
        .exec_resp       (exec_resp),
        .pop             (pop),
        .exec_req_valid  (exec_req_valid),
        .exec_req        (exec_req),
        .update_valid    (update_valid),
        .update          (update),
        .redirect        (redirect),
        .redirect_pc     (redirect_pc),
        .mispredict      (mispredict),
        .retire_valid    (retire_valid)
    );

endmodule

/* sim/frontend_checker.sv */
module frontend_checker #(
    parameter logic [bp_pkg::ADDR_W-1:0] LOOP_PC = '0
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               exec_req_valid,
    input  bp_pkg::fetch_rec_t exec_req,
    input  logic               exec_resp_valid,
    input  bp_pkg::exec_resp_t exec_resp,
    input  logic               mispredict,
    input  logic               retire_valid,
    output int                 pc_errors,
    output int                 hit_errors,
    output int                 pulse_errors,
    output int                 loop_errors,
    output int                 retired,
    output int                 loop_seen
);
    import bp_pkg::*;

    logic [ADDR_W-1:0]     expected_pc;
    logic [ADDR_W-1:0]     arch_next;
    logic                  accept;
    logic                  wrong_path;
    logic                  reset_d;
    logic                  exp_retire;
    logic                  exp_mispredict;
    logic [BP_ENTRIES-1:0] branch_retired;
    logic                  exp_hit;

    // Architectural path from the outcome the execute side returned
    assign accept     = exec_req_valid && exec_resp_valid;
    assign arch_next  = (exec_resp.is_branch && exec_resp.taken) ? exec_resp.target
                                                                 : exec_req.pc + 32'd4;
    assign wrong_path = (arch_next != exec_req.pred_next);

    // Every branch that has retired once stays installed
    assign exp_hit = branch_retired[exec_req.pc[BP_INDEX_W+1:2]];

    always @(posedge clk) begin
        if (reset) begin
            expected_pc    <= RESET_PC;
            exp_retire     <= 1'b0;
            exp_mispredict <= 1'b0;
            branch_retired <= '0;
            reset_d        <= 1'b1;
        end else begin
            reset_d <= 1'b0;
            if (reset_d && exec_req_valid !== 1'b0) begin
                $display("FAILED t=%0t exec_req_valid expected 0 got %b",
                         $time, exec_req_valid);
                pulse_errors <= pulse_errors + 1;
            end
            if (retire_valid !== exp_retire) begin
                $display("FAILED t=%0t retire_valid expected %b got %b",
                         $time, exp_retire, retire_valid);
                pulse_errors <= pulse_errors + 1;
            end
            if (mispredict !== exp_mispredict) begin
                $display("FAILED t=%0t mispredict expected %b got %b",
                         $time, exp_mispredict, mispredict);
                pulse_errors <= pulse_errors + 1;
            end
            // Anything presented must lie on the architectural path
            if (exec_req_valid === 1'b1 && exec_req.pc !== expected_pc) begin
                $display("FAILED t=%0t exec_req.pc expected %h got %h",
                         $time, expected_pc, exec_req.pc);
                pc_errors <= pc_errors + 1;
            end
            if (exec_req_valid === 1'b1 && exec_req.hit !== exp_hit) begin
                $display("FAILED t=%0t exec_req.hit expected %b got %b",
                         $time, exp_hit, exec_req.hit);
                hit_errors <= hit_errors + 1;
            end
            exp_retire     <= accept;
            exp_mispredict <= accept && wrong_path;
            if (accept) begin
                expected_pc <= arch_next;
                retired     <= retired + 1;
                if (exec_resp.is_branch) begin
                    branch_retired[exec_req.pc[BP_INDEX_W+1:2]] <= 1'b1;
                end
                if (exec_req.pc == LOOP_PC) begin
                    if (loop_seen == 0 && !wrong_path) begin
                        $display("t=%0t loop branch was not mispredicted on first retirement",
                                 $time);
                        loop_errors <= loop_errors + 1;
                    end
                    if (loop_seen > 0 && exec_req.pred_next !== exec_resp.target) begin
                        $display("FAILED t=%0t exec_req.pred_next expected %h got %h",
                                 $time, exec_resp.target, exec_req.pred_next);
                        loop_errors <= loop_errors + 1;
                    end
                    loop_seen <= loop_seen + 1;
                end
            end
        end
    end

endmodule

/* sim/branch_frontend_tb.sv */
module branch_frontend_tb;
    import bp_pkg::*;

    localparam int PROG_WORDS = 16;
    localparam logic [ADDR_W-1:0] LOOP_PC = 32'h14;
    localparam int NUM_PHASES = 4;
    localparam int RETIRE_PER_PHASE = 60;
    localparam int MAX_STALL = 12;
    // Worst refill after a redirect, plus margin
    localparam int REFILL_CYCLES = 8;
    localparam int WATCHDOG_TIME =
        NUM_PHASES * RETIRE_PER_PHASE * (MAX_STALL + REFILL_CYCLES) * 10;

    // Percent chance per record that the response is held back
    localparam logic [NUM_PHASES-1:0][7:0] STALL_PCT = {8'd95, 8'd60, 8'd25, 8'd0};

    logic       clk;
    logic       reset;
    logic       exec_resp_valid;
    exec_resp_t exec_resp;
    logic       exec_req_valid;
    fetch_rec_t exec_req;
    logic       mispredict;
    logic       retire_valid;

    int pc_errors;
    int hit_errors;
    int pulse_errors;
    int loop_errors;
    int retired;
    int loop_seen;

    exec_resp_t program_table [PROG_WORDS];

    branch_frontend branch_frontend_inst (
        .clk             (clk),
        .reset           (reset),
        .exec_resp_valid (exec_resp_valid),
        .exec_resp       (exec_resp),
        .exec_req_valid  (exec_req_valid),
        .exec_req        (exec_req),
        .mispredict      (mispredict),
        .retire_valid    (retire_valid)
    );

    frontend_checker #(
        .LOOP_PC (LOOP_PC)
    ) frontend_checker_inst (
        .clk             (clk),
        .reset           (reset),
        .exec_req_valid  (exec_req_valid),
        .exec_req        (exec_req),
        .exec_resp_valid (exec_resp_valid),
        .exec_resp       (exec_resp),
        .mispredict      (mispredict),
        .retire_valid    (retire_valid),
        .pc_errors       (pc_errors),
        .hit_errors      (hit_errors),
        .pulse_errors    (pulse_errors),
        .loop_errors     (loop_errors),
        .retired         (retired),
        .loop_seen       (loop_seen)
    );

    task automatic load_branch(input int word, input logic taken,
                               input logic [ADDR_W-1:0] target);
        program_table[word].is_branch = 1'b1;
        program_table[word].taken     = taken;
        program_table[word].target    = target;
    endtask

    // Outside the program every word is a plain instruction
    function automatic exec_resp_t program_resp(input logic [ADDR_W-1:0] pc);
        exec_resp_t resp;
        resp = '0;
        if (pc[ADDR_W-1:2] < PROG_WORDS) begin
            resp = program_table[pc[5:2]];
        end
        return resp;
    endfunction

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("watchdog expired at t=%0t with only %0d instructions retired",
                 $time, retired);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        int total;
        int phase;
        int delay;

        void'($urandom(31327));
        reset           = 1'b1;
        exec_resp_valid = 1'b0;
        exec_resp       = '0;
        for (int i = 0; i < PROG_WORDS; i++) begin
            program_table[i] = '0;
        end
        load_branch(1, 1'b0, 32'h40);
        // Forward jump over word 3
        load_branch(2, 1'b1, 32'h10);
        load_branch(5, 1'b1, 32'h00);

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (phase = 0; phase < NUM_PHASES; phase++) begin
            while (retired < (phase + 1) * RETIRE_PER_PHASE) begin
                exec_resp_valid = 1'b0;
                if (exec_req_valid) begin
                    if ($urandom_range(99) < STALL_PCT[phase]) begin
                        delay = $urandom_range(MAX_STALL, 1);
                        repeat (delay) @(negedge clk);
                    end
                    exec_resp       = program_resp(exec_req.pc);
                    exec_resp_valid = 1'b1;
                end
                @(negedge clk);
            end
        end
        exec_resp_valid = 1'b0;
        repeat (3) @(negedge clk);

        total = pc_errors + hit_errors + pulse_errors + loop_errors;
        if (loop_seen < 2) begin
            $display("loop branch at %h retired fewer than twice", LOOP_PC);
            total = total + 1;
        end
        $display("errors: pc %0d, hit %0d, pulses %0d, loop %0d, total %0d; retired %0d",
                 pc_errors, hit_errors, pulse_errors, loop_errors, total, retired);
        if (total == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* branch_frontend.f */
verilog/bp_pkg.sv
verilog/branch_predictor.sv
verilog/fetch_pc_gen.sv
verilog/fetch_queue.sv
verilog/branch_resolve.sv
verilog/branch_frontend.sv
sim/frontend_checker.sv
sim/branch_frontend_tb.sv
